// ==== Bender.yml ====
package:
  name: str_dot

sources:
  - str_pkg.sv
  - str_if.sv
  - str_birs.sv
  - str_fork.sv
  - str_add_tree.sv
  - str_dot_branch.sv
  - str_join.sv
  - str_dot_top.sv
  - target: test
    files:
      - str_dot_assert.sv
      - tb_str_dot.sv

// ==== str_add_tree.sv ====
`timescale 1ns/100ps

module str_add_tree #(
    parameter int ch    = 4,
    parameter int in_w  = 12,
    parameter int out_w = in_w + $clog2(ch)
) (
    input  logic                    clk,
    input  logic                    rst,
    // lanes are read as signed values
    input  logic [ch-1:0][in_w-1:0] in_data,
    input  logic                    in_last,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic signed [out_w-1:0] out_data,
    output logic                    out_last,
    output logic                    out_valid,
    input  logic                    out_ready
);
    localparam int stg = $clog2(ch);
    localparam int ech = 1 << stg;

    wire signed [out_w-1:0] node [stg+1][ech];
    wire                    node_last  [stg+1];
    wire                    node_valid [stg+1];
    wire                    node_ready [stg+1];

    if (ch < 2) begin : g_ch_check
        $error("str_add_tree needs ch >= 2");
    end
    if (out_w != in_w + stg) begin : g_w_check
        $error("str_add_tree needs out_w = in_w + clog2(ch)");
    end

    // pad with zeros up to the next power of two
    for (genvar i = 0; i < ech; i++) begin : g_pad
        if (i < ch) begin : g_in
            assign node[0][i] = out_w'($signed(in_data[i]));
        end else begin : g_zero
            assign node[0][i] = '0;
        end
    end

    assign node_last[0]  = in_last;
    assign node_valid[0] = in_valid;
    assign in_ready      = node_ready[0];

    for (genvar s = 0; s < stg; s++) begin : g_stage
        localparam int iw = in_w + s;
        localparam int ow = iw + 1;
        localparam int n  = ech >> (s + 1);

        logic q_last;
        logic q_valid;
        logic hs;

        // one forward slice per layer, lane 0 owns the handshake
        assign hs              = node_valid[s] & node_ready[s];
        assign node_ready[s]   = ~q_valid | node_ready[s+1];
        assign node_valid[s+1] = q_valid;
        assign node_last[s+1]  = q_last;

        always_ff @(posedge clk) begin
            if (rst) begin
                q_valid <= 1'b0;
            end else if (hs) begin
                q_valid <= 1'b1;
            end else if (node_ready[s+1]) begin
                q_valid <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (hs) begin
                q_last <= node_last[s];
            end
        end

        // only the lanes that the next layer reads get an adder
        for (genvar i = 0; i < n; i++) begin : g_lane
            logic signed [ow-1:0]    sum;
            logic signed [out_w-1:0] q;

            assign sum = ow'($signed(node[s][2*i][iw-1:0]))
                       + ow'($signed(node[s][2*i+1][iw-1:0]));

            always_ff @(posedge clk) begin
                if (hs) begin
                    q <= out_w'(sum);
                end
            end

            assign node[s+1][i] = q;
        end
    end

    assign out_data        = node[stg][0];
    assign out_last        = node_last[stg];
    assign out_valid       = node_valid[stg];
    assign node_ready[stg] = out_ready;
endmodule

// ==== str_birs.sv ====
`timescale 1ns/100ps

module str_birs #(
    parameter type payload_t = logic
) (
    input logic   clk,
    input logic   rst,
    str_if.sink   up,
    str_if.source down
);
    payload_t   mem_data [2];
    logic       mem_last [2];
    logic       wp;
    logic       rp;
    logic [1:0] count;
    logic       up_hs;
    logic       down_hs;

    assign up_hs   = up.valid & up.ready;
    assign down_hs = down.valid & down.ready;

    // ready and valid come from the occupancy only, so neither path is combinational
    assign up.ready   = count < 2'd2;
    assign down.valid = count != 2'd0;
    assign down.data  = mem_data[rp];
    assign down.last  = mem_last[rp];

    always_ff @(posedge clk) begin
        if (rst) begin
            wp    <= 1'b0;
            rp    <= 1'b0;
            count <= 2'd0;
        end else begin
            if (up_hs) begin
                wp <= ~wp;
            end
            if (down_hs) begin
                rp <= ~rp;
            end
            case ({up_hs, down_hs})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (up_hs) begin
            mem_data[wp] <= up.data;
            mem_last[wp] <= up.last;
        end
    end
endmodule

// ==== str_dot_assert.sv ====
`timescale 1ns/100ps

module str_dot_assert
    import str_pkg::*;
#(
    parameter int  ch    = default_ch,
    localparam int dot_w = prod_w + $clog2(ch),
    localparam int sum_w = data_w + $clog2(ch)
) (
    input logic                    clk,
    input logic                    rst,
    input logic signed [dot_w-1:0] out_dot,
    input logic signed [sum_w-1:0] out_sum,
    input logic                    out_last,
    input logic                    out_valid,
    input logic                    out_ready
);
    // a result leaves only through a transfer
    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        $fell(out_valid) |-> $past(out_ready))
        else $error("out_valid fell without a transfer");

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_dot) && $stable(out_sum) && $stable(out_last))
        else $error("output payload changed while stalled");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high during reset");
endmodule

// ==== str_dot_branch.sv ====
`timescale 1ns/100ps

module str_dot_branch
    import str_pkg::*;
#(
    parameter int ch = default_ch
) (
    input logic   clk,
    input logic   rst,
    str_if.sink   up,
    str_if.source down
);
    localparam int dot_w = dot_width(ch);

    prod_t [ch-1:0] prod_d;
    prod_t [ch-1:0] prod_q;
    logic           prod_last;
    logic           prod_valid;
    logic           prod_ready;
    logic           up_hs;

    assign up_hs    = up.valid & up.ready;
    assign up.ready = ~prod_valid | prod_ready;

    for (genvar i = 0; i < ch; i++) begin : g_mul
        logic signed [2*data_w-1:0] full;

        assign full = up.data.a[i] * up.data.b[i];
        // arithmetic shift, so negative products round toward minus infinity
        assign prod_d[i] = prod_t'(full >>> prod_shift);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
        end else if (up_hs) begin
            prod_valid <= 1'b1;
        end else if (prod_ready) begin
            prod_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (up_hs) begin
            prod_q    <= prod_d;
            prod_last <= up.last;
        end
    end

    str_add_tree #(
        .ch    (ch),
        .in_w  (prod_w),
        .out_w (dot_w)
    ) u_tree (
        .clk       (clk),
        .rst       (rst),
        .in_data   (prod_q),
        .in_last   (prod_last),
        .in_valid  (prod_valid),
        .in_ready  (prod_ready),
        .out_data  (down.data),
        .out_last  (down.last),
        .out_valid (down.valid),
        .out_ready (down.ready)
    );
endmodule

// ==== str_dot_top.sv ====
`timescale 1ns/100ps

module str_dot_top
    import str_pkg::*;
#(
    parameter int  ch    = default_ch,
    localparam int dot_w = dot_width(ch),
    localparam int sum_w = sum_width(ch)
) (
    input  logic                    clk,
    input  logic                    rst,
    input  sample_t                 in_a [ch],
    input  sample_t                 in_b [ch],
    input  logic                    in_last,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic signed [dot_w-1:0] out_dot,
    output logic signed [sum_w-1:0] out_sum,
    output logic                    out_last,
    output logic                    out_valid,
    input  logic                    out_ready
);
    typedef struct packed {
        sample_t [ch-1:0] a;
        sample_t [ch-1:0] b;
    } vec_t;

    typedef logic signed [dot_w-1:0] dot_t;
    typedef logic signed [sum_w-1:0] sum_t;

    typedef struct packed {
        dot_t dot;
        sum_t sum;
    } res_t;

    str_if #(.payload_t(vec_t)) in_link ();
    str_if #(.payload_t(vec_t)) prod_in ();
    str_if #(.payload_t(vec_t)) sum_in ();
    str_if #(.payload_t(dot_t)) prod_out ();
    str_if #(.payload_t(sum_t)) sum_out ();
    str_if #(.payload_t(res_t)) res_link ();

    always_comb begin
        for (int i = 0; i < ch; i++) begin
            in_link.data.a[i] = in_a[i];
            in_link.data.b[i] = in_b[i];
        end
    end

    assign in_link.last  = in_last;
    assign in_link.valid = in_valid;
    assign in_ready      = in_link.ready;

    str_fork #(
        .payload_t(vec_t)
    ) u_fork (
        .clk   (clk),
        .rst   (rst),
        .up    (in_link),
        .left  (prod_in),
        .right (sum_in)
    );

    str_dot_branch #(
        .ch(ch)
    ) u_dot (
        .clk  (clk),
        .rst  (rst),
        .up   (prod_in),
        .down (prod_out)
    );

    // the sum branch has the same tree as the dot branch, fed with the a samples
    str_add_tree #(
        .ch    (ch),
        .in_w  (data_w),
        .out_w (sum_w)
    ) u_sum (
        .clk       (clk),
        .rst       (rst),
        .in_data   (sum_in.data.a),
        .in_last   (sum_in.last),
        .in_valid  (sum_in.valid),
        .in_ready  (sum_in.ready),
        .out_data  (sum_out.data),
        .out_last  (),
        .out_valid (sum_out.valid),
        .out_ready (sum_out.ready)
    );

    str_join #(
        .payload_t(res_t)
    ) u_join (
        .clk    (clk),
        .rst    (rst),
        .dot_in (prod_out),
        .sum_in (sum_out),
        .down   (res_link)
    );

    assign out_dot        = res_link.data.dot;
    assign out_sum        = res_link.data.sum;
    assign out_last       = res_link.last;
    assign out_valid      = res_link.valid;
    assign res_link.ready = out_ready;
endmodule

// ==== str_fork.sv ====
`timescale 1ns/100ps

module str_fork #(
    parameter type payload_t = logic
) (
    input logic   clk,
    input logic   rst,
    str_if.sink   up,
    str_if.source left,
    str_if.source right
);
    str_if #(.payload_t(payload_t)) to_left ();
    str_if #(.payload_t(payload_t)) to_right ();

    // one upstream, two downstream
    // each slice only sees valid when its partner can also load
    assign up.ready       = to_left.ready & to_right.ready;
    assign to_left.valid  = up.valid & to_right.ready;
    assign to_right.valid = up.valid & to_left.ready;

    assign to_left.data  = up.data;
    assign to_left.last  = up.last;
    assign to_right.data = up.data;
    assign to_right.last = up.last;

    // the slices decouple the two branches after the split
    str_birs #(
        .payload_t(payload_t)
    ) u_left_rs (
        .clk  (clk),
        .rst  (rst),
        .up   (to_left),
        .down (left)
    );

    str_birs #(
        .payload_t(payload_t)
    ) u_right_rs (
        .clk  (clk),
        .rst  (rst),
        .up   (to_right),
        .down (right)
    );
endmodule

// ==== str_if.sv ====
`timescale 1ns/100ps

// valid/ready stream with a last flag
interface str_if #(
    parameter type payload_t = logic
);
    payload_t data;
    logic     last;
    logic     valid;
    logic     ready;

    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );
endinterface

// ==== str_join.sv ====
`timescale 1ns/100ps

module str_join #(
    parameter type payload_t = logic
) (
    input logic   clk,
    input logic   rst,
    str_if.sink   dot_in,
    str_if.sink   sum_in,
    str_if.source down
);
    logic load_ok;
    logic take;

    assign load_ok = ~down.valid | down.ready;

    // two upstream, one downstream
    // neither side is consumed until the other side has a result too
    assign dot_in.ready = sum_in.valid & load_ok;
    assign sum_in.ready = dot_in.valid & load_ok;
    assign take         = dot_in.valid & sum_in.valid & load_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            down.valid <= 1'b0;
        end else if (take) begin
            down.valid <= 1'b1;
        end else if (down.ready) begin
            down.valid <= 1'b0;
        end
    end

    // dot product in the upper field, sum in the lower one
    always_ff @(posedge clk) begin
        if (take) begin
            down.data <= payload_t'({dot_in.data, sum_in.data});
            down.last <= dot_in.last;
        end
    end
endmodule

// ==== str_pkg.sv ====
package str_pkg;

    // a and b samples are Q1.7
    localparam int data_w = 8;
    localparam int frac_w = 7;

    // one product after truncation
    localparam int prod_w      = 12;
    localparam int prod_frac_w = 10;

    // right shift from the full Q2.14 product down to Q2.10
    localparam int prod_shift = 2 * frac_w - prod_frac_w;

    // pairs per beat unless the top level says otherwise
    localparam int default_ch = 4;

    typedef logic signed [data_w-1:0] sample_t;
    typedef logic signed [prod_w-1:0] prod_t;

    // the adder tree grows by one bit per stage
    function automatic int dot_width(int ch);
        return prod_w + $clog2(ch);
    endfunction

    function automatic int sum_width(int ch);
        return data_w + $clog2(ch);
    endfunction

endpackage

// ==== tb_str_dot.sv ====
`timescale 1ns/100ps

module tb_str_dot
    import str_pkg::*;
();
    localparam int ch      = 4;
    localparam int dot_w   = prod_w + $clog2(ch);
    localparam int sum_w   = data_w + $clog2(ch);
    localparam int n_beats = 16;
    localparam int latency = 5;
    localparam int limit   = 400;

    logic                    clk = 1'b0;
    logic                    rst;
    sample_t                 in_a [ch];
    sample_t                 in_b [ch];
    logic                    in_last;
    logic                    in_valid;
    logic                    in_ready;
    logic signed [dot_w-1:0] out_dot;
    logic signed [sum_w-1:0] out_sum;
    logic                    out_last;
    logic                    out_valid;
    logic                    out_ready;

    // one row per beat: a, b, last, expected dot product, expected sum of a
    sample_t tab_a    [n_beats][ch];
    sample_t tab_b    [n_beats][ch];
    logic    tab_last [n_beats];
    int      tab_dot  [n_beats];
    int      tab_sum  [n_beats];
    int      n_tab = 0;

    int exp_q [$];
    int rcv_count    = 0;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle        = 0;
    int first_acc    = -1;
    int first_out    = -1;
    bit random_ready = 1'b0;
    bit timed_out    = 1'b0;

    always #10 clk = ~clk;

    str_dot_top #(
        .ch(ch)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_dot   (out_dot),
        .out_sum   (out_sum),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind str_dot_top str_dot_assert #(
        .ch(ch)
    ) u_proto (
        .clk       (clk),
        .rst       (rst),
        .out_dot   (out_dot),
        .out_sum   (out_sum),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic add_vector(input int a0, a1, a2, a3, b0, b1, b2, b3,
                              input logic last, input int dot, input int sum);
        tab_a[n_tab] = '{sample_t'(a0), sample_t'(a1), sample_t'(a2), sample_t'(a3)};
        tab_b[n_tab] = '{sample_t'(b0), sample_t'(b1), sample_t'(b2), sample_t'(b3)};
        tab_last[n_tab] = last;
        tab_dot[n_tab]  = dot;
        tab_sum[n_tab]  = sum;
        n_tab++;
    endtask

    // each product term is floor(a*b / 16)
    task automatic load_table();
        add_vector(   0,    0,    0,    0,     0,    0,    0,    0, 1'b0,     0,    0);
        add_vector(  16,   16,   16,   16,    16,   16,   16,   16, 1'b0,    64,   64);
        add_vector( 127,  127,  127,  127,   127,  127,  127,  127, 1'b1,  4032,  508);
        add_vector(-128, -128, -128, -128,  -128, -128, -128, -128, 1'b0,  4096, -512);
        add_vector(-128, -128, -128, -128,   127,  127,  127,  127, 1'b1, -4064, -512);
        add_vector(   1,    2,    3,    4,    16,   32,   48,   64, 1'b0,    30,   10);
        add_vector(  -1,   -1,   -1,   -1,     1,    1,    1,    1, 1'b0,    -4,   -4);
        add_vector(   1,    1,    1,    1,    15,   15,   15,   15, 1'b1,     0,    4);
        add_vector(  -5,    7,   -9,   11,     3,   -2,    4,   -6, 1'b0,   -10,    4);
        add_vector( 100, -100,   50,  -50,   100,  100,  -40,  -40, 1'b0,     0,    0);
        add_vector(  64,  -64,   32,    0,    64,   64, -128,  127, 1'b1,  -256,   32);
        add_vector( 127, -128,  127, -128,  -128,  127,  127, -128, 1'b0,     0,   -2);
        add_vector(   3,    5,    7,    9,     3,    5,    7,    9, 1'b0,     9,   24);
        add_vector(  -3,   -5,   -7,   -9,     3,    5,    7,    9, 1'b1,   -13,  -24);
        add_vector(  20,  -30,   40,  -50,     8,    8,    8,    8, 1'b0,   -10,  -20);
        add_vector( 127,  127,  127,  127,    -1,   -1,   -1,   -1, 1'b1,   -32,  508);
    endtask

    task automatic check_value(input string name, input logic signed [31:0] actual,
                               input int expected);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // drives and checks happen away from the DUT's register updates
    always @(posedge clk) begin : monitor
        int idx;
        cycle = cycle + 1;
        if (!rst && in_valid && in_ready && first_acc < 0) begin
            first_acc = cycle;
        end
        if (!rst && out_valid && first_out < 0) begin
            first_out = cycle;
        end
        if (!rst && out_valid && out_ready) begin
            rcv_count++;
            assert (exp_q.size() > 0) else begin
                $display("output beat at %0t has no matching input beat", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                idx = exp_q.pop_front();
                check_value("out_dot", out_dot, tab_dot[idx]);
                check_value("out_sum", out_sum, tab_sum[idx]);
                check_value("out_last", out_last, tab_last[idx]);
            end
        end
    end

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ($urandom % 3) != 0;
        end
    end

    // entered on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input int idx);
        int waited;
        waited = 0;
        for (int j = 0; j < ch; j++) begin
            in_a[j] = tab_a[idx][j];
            in_b[j] = tab_b[idx][j];
        end
        in_last  = tab_last[idx];
        in_valid = 1'b1;
        exp_q.push_back(idx);
        while (!in_ready && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low for %0d cycles on beat %0d", limit, idx);
            timed_out = 1'b1;
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (rcv_count < n && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (rcv_count < n) begin
            $display("timeout: only %0d of %0d results arrived", rcv_count, n);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic run_stream(input bit bp);
        rcv_count    = 0;
        first_acc    = -1;
        first_out    = -1;
        out_ready    = 1'b1;
        random_ready = bp;
        for (int i = 0; i < n_tab && !timed_out; i++) begin
            if (bp && ($urandom % 4) == 0) begin
                idle_cycles(1 + $urandom % 3);
            end
            send_beat(i);
        end
        in_valid = 1'b0;
        if (!timed_out) begin
            wait_results(n_tab);
        end
        random_ready = 1'b0;
        out_ready    = 1'b1;
        // a few more cycles so that a duplicated beat would still show up
        repeat (10) @(negedge clk);
        check_value("result count", rcv_count, n_tab);
        check_value("pending beats", exp_q.size(), 0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        int mark;
        void'($urandom(32'h42df350e));
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b1;
        for (int j = 0; j < ch; j++) begin
            in_a[j] = '0;
            in_b[j] = '0;
        end
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mark = errors;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);
        finish_test("reset state", mark);

        mark = errors;
        run_stream(1'b0);
        if (!timed_out) begin
            check_value("latency", first_out - first_acc, latency);
        end
        finish_test("full throughput", mark);

        if (!timed_out) begin
            mark = errors;
            run_stream(1'b1);
            finish_test("back-pressure", mark);
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// ==== vlog.f ====
str_pkg.sv
str_if.sv
str_birs.sv
str_fork.sv
str_add_tree.sv
str_dot_branch.sv
str_join.sv
str_dot_top.sv
str_dot_assert.sv
tb_str_dot.sv
